// ==== common/conv_geom_pkg.sv ====
package conv_geom_pkg;

    // ========================================================================
    // Frame geometry
    // ========================================================================

    localparam int IMG_WIDTH  = 8;                  // Pixels per row.
    localparam int IMG_HEIGHT = 8;                  // Rows per frame.

    // ========================================================================
    // Kernel and channels
    // ========================================================================

    localparam int KERNEL   = 3;                    // Kernel side.
    localparam int WIN_SIZE = KERNEL * KERNEL;      // Pixels in one window.

    localparam int IN_CH  = 2;
    localparam int OUT_CH = 4;

    // Position counter widths
    localparam int COL_W = $clog2(IMG_WIDTH);
    localparam int ROW_W = $clog2(IMG_HEIGHT);

endpackage

// ==== common/conv_arith_pkg.sv ====
package conv_arith_pkg;

    // ========================================================================
    // Scalar types
    // ========================================================================

    typedef logic signed [15:0] pixel_t;
    typedef logic signed [7:0]  weight_t;
    typedef logic signed [31:0] bias_t;
    typedef logic signed [47:0] acc_t;              // Wide enough for 18 taps plus bias.
    typedef logic signed [31:0] result_t;

    // ========================================================================
    // Array types
    // ========================================================================

    // Index is row * KERNEL + column, row 0 oldest, column 0 leftmost.
    typedef pixel_t window_t [conv_geom_pkg::WIN_SIZE];

    // All taps of all input channels for one output channel.
    typedef weight_t weight_set_t [conv_geom_pkg::IN_CH][conv_geom_pkg::WIN_SIZE];

    typedef weight_set_t weight_bank_t [conv_geom_pkg::OUT_CH];
    typedef bias_t       bias_bank_t   [conv_geom_pkg::OUT_CH];
    typedef result_t     result_bank_t [conv_geom_pkg::OUT_CH];

endpackage

// ==== window/window_gen.sv ====
module window_gen (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    valid_in,
    input  conv_arith_pkg::pixel_t  pixel,
    output conv_arith_pkg::window_t window,
    output logic                    window_valid
);

    // Two rows back and one row back, addressed by column.
    conv_arith_pkg::pixel_t line_old [conv_geom_pkg::IMG_WIDTH];
    conv_arith_pkg::pixel_t line_mid [conv_geom_pkg::IMG_WIDTH];

    // New window column, index 0 is the oldest row.
    conv_arith_pkg::pixel_t tap [conv_geom_pkg::KERNEL];

    logic [conv_geom_pkg::COL_W-1:0] col;
    logic [conv_geom_pkg::ROW_W-1:0] row;
    logic                            last_col;
    logic                            last_row;
    logic                            full_win;

    // ========================================================================
    // Frame position
    // ========================================================================

    assign last_col = (int'(col) == conv_geom_pkg::IMG_WIDTH - 1);
    assign last_row = (int'(row) == conv_geom_pkg::IMG_HEIGHT - 1);
    assign full_win = (int'(row) >= conv_geom_pkg::KERNEL - 1) &&
                      (int'(col) >= conv_geom_pkg::KERNEL - 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col <= '0;
            row <= '0;
        end else if (valid_in) begin
            if (last_col) begin
                col <= '0;
                row <= last_row ? '0 : row + 1'b1;  // Wrap at end of frame.
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            window_valid <= 1'b0;
        end else begin
            window_valid <= valid_in && full_win;   // Single cycle per accepted pixel.
        end
    end

    // ========================================================================
    // Line buffers
    // ========================================================================

    assign tap[0] = line_old[col];
    assign tap[1] = line_mid[col];
    assign tap[2] = pixel;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < conv_geom_pkg::IMG_WIDTH; i++) begin
                line_old[i] <= '0;
                line_mid[i] <= '0;
            end
        end else if (valid_in) begin
            line_old[col] <= line_mid[col];         // Age this column by one row.
            line_mid[col] <= pixel;
        end
    end

    // ========================================================================
    // Shift window
    // ========================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < conv_geom_pkg::WIN_SIZE; i++) begin
                window[i] <= '0;
            end
        end else if (valid_in) begin
            for (int r = 0; r < conv_geom_pkg::KERNEL; r++) begin
                for (int c = 0; c < conv_geom_pkg::KERNEL - 1; c++) begin
                    window[r * conv_geom_pkg::KERNEL + c] <=
                        window[r * conv_geom_pkg::KERNEL + c + 1];
                end
                // Newest pixel enters at the right edge.
                window[r * conv_geom_pkg::KERNEL + conv_geom_pkg::KERNEL - 1] <= tap[r];
            end
        end
    end

endmodule

// ==== design/conv_mac.sv ====
module conv_mac (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         window_valid,
    input  conv_arith_pkg::window_t      window_ch [conv_geom_pkg::IN_CH],
    input  conv_arith_pkg::weight_bank_t weights,
    input  conv_arith_pkg::bias_bank_t   biases,
    output conv_arith_pkg::result_bank_t result,
    output logic                         result_valid
);

    conv_arith_pkg::acc_t    acc  [conv_geom_pkg::OUT_CH];
    conv_arith_pkg::result_t relu [conv_geom_pkg::OUT_CH];

    // ========================================================================
    // Weighted sum over all input channels
    // ========================================================================

    always_comb begin
        for (int oc = 0; oc < conv_geom_pkg::OUT_CH; oc++) begin
            acc[oc] = conv_arith_pkg::acc_t'(biases[oc]);
            for (int ic = 0; ic < conv_geom_pkg::IN_CH; ic++) begin
                for (int k = 0; k < conv_geom_pkg::WIN_SIZE; k++) begin
                    acc[oc] = acc[oc] +
                        conv_arith_pkg::acc_t'(window_ch[ic][k]) *
                        conv_arith_pkg::acc_t'(weights[oc][ic][k]);
                end
            end
        end
    end

    // ReLU, then keep the low 32 bits.
    always_comb begin
        for (int oc = 0; oc < conv_geom_pkg::OUT_CH; oc++) begin
            if (acc[oc] < 0) begin
                relu[oc] = '0;
            end else begin
                relu[oc] = conv_arith_pkg::result_t'(acc[oc]);
            end
        end
    end

    // ========================================================================
    // Result register
    // ========================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result_valid <= 1'b0;
            for (int oc = 0; oc < conv_geom_pkg::OUT_CH; oc++) begin
                result[oc] <= '0;
            end
        end else begin
            result_valid <= window_valid;
            if (window_valid) begin
                for (int oc = 0; oc < conv_geom_pkg::OUT_CH; oc++) begin
                    result[oc] <= relu[oc];         // Held until the next window.
                end
            end
        end
    end

endmodule

// ==== design/conv_top.sv ====
module conv_top (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         valid_in,
    input  conv_arith_pkg::pixel_t       in_pixel [conv_geom_pkg::IN_CH],
    input  conv_arith_pkg::weight_bank_t weights,
    input  conv_arith_pkg::bias_bank_t   biases,
    output conv_arith_pkg::result_bank_t result,
    output logic                         result_valid
);

    conv_arith_pkg::window_t window_ch [conv_geom_pkg::IN_CH];
    logic                    window_valid;

    // ========================================================================
    // Window generators, one per input channel
    // ========================================================================

    // All generators see the same strobes, so channel 0 alone times the MAC.
    for (genvar ch = 0; ch < conv_geom_pkg::IN_CH; ch++) begin : g_win
        if (ch == 0) begin : g_lead
            window_gen u_win (
                .clk          (clk),
                .rst_n        (rst_n),
                .valid_in     (valid_in),
                .pixel        (in_pixel[ch]),
                .window       (window_ch[ch]),
                .window_valid (window_valid)
            );
        end else begin : g_follow
            window_gen u_win (
                .clk          (clk),
                .rst_n        (rst_n),
                .valid_in     (valid_in),
                .pixel        (in_pixel[ch]),
                .window       (window_ch[ch]),
                .window_valid ()
            );
        end
    end

    // ========================================================================
    // MAC stage
    // ========================================================================

    conv_mac u_mac (
        .clk          (clk),
        .rst_n        (rst_n),
        .window_valid (window_valid),
        .window_ch    (window_ch),
        .weights      (weights),
        .biases       (biases),
        .result       (result),
        .result_valid (result_valid)
    );

endmodule

// ==== bench/conv_assert.sv ====
module conv_assert (
    input logic                         clk,
    input logic                         rst_n,
    input logic                         window_valid,
    input conv_arith_pkg::acc_t         acc [conv_geom_pkg::OUT_CH],
    input conv_arith_pkg::result_bank_t result,
    input logic                         result_valid
);

    timeunit 1ns;
    timeprecision 1ps;

    // Every window yields a result on the next cycle.
    valid_follows: assert property (@(posedge clk) disable iff (!rst_n)
        window_valid |=> result_valid)
        else $error("result_valid did not follow window_valid");

    // No result strobe without a window one cycle earlier.
    valid_source: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid |-> $past(window_valid))
        else $error("result_valid without a preceding window_valid");

    // Sums below 2^31 never show a negative result.
    for (genvar oc = 0; oc < conv_geom_pkg::OUT_CH; oc++) begin : g_sign
        sign_ok: assert property (@(posedge clk) disable iff (!rst_n)
            (window_valid && acc[oc] < 48'sh0000_8000_0000) |=> !result[oc][31])
            else $error("negative result on output channel %0d", oc);
    end

endmodule

bind conv_mac conv_assert u_assert (
    .clk          (clk),
    .rst_n        (rst_n),
    .window_valid (window_valid),
    .acc          (acc),
    .result       (result),
    .result_valid (result_valid)
);

// ==== bench/conv_tb.sv ====
module conv_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 16;
    localparam int PIXELS       = conv_geom_pkg::IMG_WIDTH * conv_geom_pkg::IMG_HEIGHT;
    localparam int OUT_W        = conv_geom_pkg::IMG_WIDTH - conv_geom_pkg::KERNEL + 1;
    localparam int OUT_H        = conv_geom_pkg::IMG_HEIGHT - conv_geom_pkg::KERNEL + 1;
    localparam int WINDOWS      = OUT_W * OUT_H;
    localparam int NUM_FRAMES   = 6;
    // At most four cycles per pixel, doubled for margin.
    localparam int WATCHDOG_CYCLES = 2 * (RESET_CYCLES + NUM_FRAMES * PIXELS * 4);

    logic                         clk = 1'b0;
    logic                         rst_n;
    logic                         valid_in;
    conv_arith_pkg::pixel_t       in_pixel [conv_geom_pkg::IN_CH];
    conv_arith_pkg::weight_bank_t weights;
    conv_arith_pkg::bias_bank_t   biases;
    conv_arith_pkg::result_bank_t result;
    logic                         result_valid;

    conv_arith_pkg::pixel_t  frame [conv_geom_pkg::IN_CH][PIXELS];
    conv_arith_pkg::result_t exp_q [$];                 // OUT_CH entries per window.
    int                      exp_cyc_q [$];
    int                      exp_win_q [$];
    conv_arith_pkg::result_t exp_val;
    int                      exp_cyc;
    int                      exp_win;

    logic [31:0] lcg_state     = 32'd11753;
    int          cyc           = 0;
    int          rx_count      = 0;
    bit          seen_result   = 1'b0;
    int          value_errors  = 0;
    int          timing_errors = 0;
    int          missing_count = 0;
    int          extra_count   = 0;
    int          other_errors  = 0;

    conv_top UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .valid_in     (valid_in),
        .in_pixel     (in_pixel),
        .weights      (weights),
        .biases       (biases),
        .result       (result),
        .result_valid (result_valid)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // ========================================================================
    // Stimulus and reference model
    // ========================================================================

    function automatic logic signed [15:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[31:16];
    endfunction

    // Expected output of channel oc for the k-th window of the stored frame.
    function automatic conv_arith_pkg::result_t ref_result(input int k, input int oc);
        conv_arith_pkg::acc_t sum;
        int                   r0;
        int                   c0;
        int                   idx;
        r0  = k / OUT_W;
        c0  = k % OUT_W;
        sum = conv_arith_pkg::acc_t'(biases[oc]);
        for (int ic = 0; ic < conv_geom_pkg::IN_CH; ic++) begin
            for (int wr = 0; wr < conv_geom_pkg::KERNEL; wr++) begin
                for (int wc = 0; wc < conv_geom_pkg::KERNEL; wc++) begin
                    idx = (r0 + wr) * conv_geom_pkg::IMG_WIDTH + c0 + wc;
                    sum = sum + conv_arith_pkg::acc_t'(frame[ic][idx]) *
                        conv_arith_pkg::acc_t'(weights[oc][ic][wr * conv_geom_pkg::KERNEL + wc]);
                end
            end
        end
        if (sum < 0) begin
            return '0;                                  // ReLU.
        end
        return sum[31:0];
    endfunction

    task automatic randomize_params();
        for (int oc = 0; oc < conv_geom_pkg::OUT_CH; oc++) begin
            biases[oc] = conv_arith_pkg::bias_t'(lcg_next());
            for (int ic = 0; ic < conv_geom_pkg::IN_CH; ic++) begin
                for (int k = 0; k < conv_geom_pkg::WIN_SIZE; k++) begin
                    weights[oc][ic][k] = conv_arith_pkg::weight_t'(lcg_next());
                end
            end
        end
    endtask

    task automatic fill_frame(input bit max_level);
        for (int ch = 0; ch < conv_geom_pkg::IN_CH; ch++) begin
            for (int i = 0; i < PIXELS; i++) begin
                frame[ch][i] = max_level ? 16'sh7FFF : lcg_next();
            end
        end
    endtask

    task automatic send_frame(input int max_gap);
        int gap;
        int row;
        int col;
        int k;
        for (int i = 0; i < PIXELS; i++) begin
            gap = (max_gap > 0) ? int'($unsigned(lcg_next())) % (max_gap + 1) : 0;
            repeat (gap) begin
                @(negedge clk);
                valid_in = 1'b0;
            end
            @(negedge clk);
            valid_in = 1'b1;
            for (int ch = 0; ch < conv_geom_pkg::IN_CH; ch++) begin
                in_pixel[ch] = frame[ch][i];
            end
            row = i / conv_geom_pkg::IMG_WIDTH;
            col = i % conv_geom_pkg::IMG_WIDTH;
            if (row >= conv_geom_pkg::KERNEL - 1 && col >= conv_geom_pkg::KERNEL - 1) begin
                k = (row - 2) * OUT_W + col - 2;
                for (int oc = 0; oc < conv_geom_pkg::OUT_CH; oc++) begin
                    exp_q.push_back(ref_result(k, oc));
                end
                exp_cyc_q.push_back(cyc);
                exp_win_q.push_back(k);
            end
        end
    endtask

    // Stops the strobes and waits for the outstanding windows, bounded.
    task automatic drain(input int start_count, input int expected);
        int waited;
        @(negedge clk);
        valid_in = 1'b0;
        waited = 0;
        while (exp_cyc_q.size() > 0 && waited < 8) begin
            @(negedge clk);
            waited++;
        end
        if (exp_cyc_q.size() > 0) begin
            $display("Error: %0d expected results never arrived", exp_cyc_q.size());
            missing_count += exp_cyc_q.size();
            exp_q.delete();
            exp_cyc_q.delete();
            exp_win_q.delete();
        end
        repeat (2) @(negedge clk);
        if (rx_count - start_count != expected) begin
            $display("Error: received %0d results where %0d windows were sent",
                     rx_count - start_count, expected);
            other_errors++;
        end
    endtask

    // ========================================================================
    // Test sequence
    // ========================================================================

    initial begin
        int start;
        rst_n    = 1'b0;
        valid_in = 1'b0;
        for (int ch = 0; ch < conv_geom_pkg::IN_CH; ch++) begin
            in_pixel[ch] = '0;
        end
        for (int oc = 0; oc < conv_geom_pkg::OUT_CH; oc++) begin
            biases[oc] = '0;
            for (int ic = 0; ic < conv_geom_pkg::IN_CH; ic++) begin
                for (int k = 0; k < conv_geom_pkg::WIN_SIZE; k++) begin
                    weights[oc][ic][k] = '0;
                end
            end
        end
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        repeat (4) @(negedge clk);                      // Idle, outputs must stay zero.

        randomize_params();
        start = rx_count;
        fill_frame(1'b0);
        send_frame(0);
        drain(start, WINDOWS);

        start = rx_count;
        fill_frame(1'b0);
        send_frame(3);                                  // Random idle gaps.
        drain(start, WINDOWS);

        randomize_params();
        for (int oc = 0; oc < conv_geom_pkg::OUT_CH; oc++) begin
            biases[oc] = (oc % 2 == 1) ? 32'sd100_000_000 : -32'sd100_000_000;
        end
        start = rx_count;
        fill_frame(1'b0);
        send_frame(0);
        drain(start, WINDOWS);
        for (int oc = 0; oc < conv_geom_pkg::OUT_CH; oc++) begin
            if ((oc % 2 == 0 && result[oc] != 0) || (oc % 2 == 1 && result[oc] <= 0)) begin
                $display("Error %0t ns: result[%0d] has the wrong sign for its bias, got %0d",
                         $time, oc, result[oc]);
                other_errors++;
            end
        end

        // Sums beyond the signed 32-bit range.
        for (int oc = 0; oc < conv_geom_pkg::OUT_CH; oc++) begin
            biases[oc] = 32'sh7FFF_FFFF;
            for (int ic = 0; ic < conv_geom_pkg::IN_CH; ic++) begin
                for (int k = 0; k < conv_geom_pkg::WIN_SIZE; k++) begin
                    weights[oc][ic][k] = 8'sd127;
                end
            end
        end
        start = rx_count;
        fill_frame(1'b1);
        send_frame(0);
        drain(start, WINDOWS);

        // Two frames back to back across the counter wrap.
        randomize_params();
        start = rx_count;
        fill_frame(1'b0);
        send_frame(0);
        fill_frame(1'b0);
        send_frame(0);
        drain(start, 2 * WINDOWS);

        $display("Error counts: %0d value, %0d timing, %0d missing, %0d extra, %0d other",
                 value_errors, timing_errors, missing_count, extra_count, other_errors);
        if (value_errors + timing_errors + missing_count + extra_count + other_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // ========================================================================
    // Comparison and watchdog
    // ========================================================================

    always @(negedge clk) begin
        if (rst_n && result_valid) begin
            if (exp_cyc_q.size() == 0) begin
                $display("Error %0t ns: result_valid pulsed with no window outstanding", $time);
                extra_count++;
            end else begin
                exp_cyc = exp_cyc_q.pop_front();
                exp_win = exp_win_q.pop_front();
                if (cyc != exp_cyc + 2) begin
                    $display("Error %0t ns: result_valid cycle expected %0d actual %0d",
                             $time, exp_cyc + 2, cyc);
                    timing_errors++;
                end
                for (int oc = 0; oc < conv_geom_pkg::OUT_CH; oc++) begin
                    exp_val = exp_q.pop_front();
                    if (result[oc] !== exp_val) begin
                        $display("Error %0t ns: result[%0d] window %0d expected %0d actual %0d",
                                 $time, oc, exp_win, exp_val, result[oc]);
                        value_errors++;
                    end
                end
                rx_count++;
                seen_result = 1'b1;
            end
        end else if (rst_n && !seen_result) begin
            for (int oc = 0; oc < conv_geom_pkg::OUT_CH; oc++) begin
                if (result[oc] !== '0) begin
                    $display("Error %0t ns: result[%0d] expected 0 actual %0d",
                             $time, oc, result[oc]);
                    value_errors++;
                end
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Error: watchdog expired before the tests finished");
        $display("tests failed");
        $finish;
    end

endmodule

// ==== project.f ====
common/conv_geom_pkg.sv
common/conv_arith_pkg.sv
window/window_gen.sv
design/conv_mac.sv
design/conv_top.sv
bench/conv_assert.sv
bench/conv_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the convolution testbench with Verilator, run it and check the log.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module conv_tb \
    -f project.f -o conv_sim || { echo "Verilator build failed"; exit 1; }
./obj_dir/conv_sim > sim.log 2>&1 || { cat sim.log; echo "Simulation stopped"; exit 1; }
cat sim.log
grep -q "tests failed" sim.log && exit 1 || exit 0
